/* dmem.f */
verilog/dmem_pkg.sv
verilog/dmem_req_if.sv
verilog/dmem_decode.sv
verilog/dmem_ctrl.sv
verilog/dmem_sram.sv
verilog/dmem_amo_alu.sv
verilog/dmem_write_merge.sv
verilog/dmem_load_align.sv
verilog/dmem_top.sv
test/dmem_sva.sv
test/tb_dmem.sv

/* run.sh */
#!/bin/sh
# Builds the dmem testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dmem -f dmem.f -o tb_dmem > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/tb_dmem > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi
exit 0

/* test/dmem_sva.sv */
/* Controller protocol checks.
   Result pulse width, result latency and the ready/result overlap. */

`timescale 1ns/1ns

module dmem_sva (
  input logic clk_i,
  input logic arst_n_i,
  input logic req_v_i,
  input logic ready_i,
  input logic resp_v_i
);

  logic accepted;

  assign accepted = req_v_i && ready_i;

  resp_single_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(resp_v_i) |-> !resp_v_i)
    else $error("v_o was high for two cycles in a row.");

  resp_after_two_edges: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(accepted, 2) |-> resp_v_i)
    else $error("v_o did not follow an accepted request after two edges.");

  resp_not_early: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(accepted) |-> !resp_v_i)
    else $error("v_o came one edge after acceptance.");

  ready_resp_apart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ready_i && resp_v_i))
    else $error("ready_o and v_o were high together.");

endmodule

bind dmem_ctrl dmem_sva u_ctrl_sva (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .req_v_i  (v_i),
  .ready_i  (ready_o),
  .resp_v_i (v_o)
);

/* test/tb_dmem.sv */
/* Testbench for the data-memory unit.
   Random loads, stores, masked ops and atomics, checked against a byte model. */

`timescale 1ns/1ns

module tb_dmem;

  localparam int addr_width_lp  = 10;
  localparam int mem_bytes_lp   = 2 ** addr_width_lp;
  localparam int clk_period_lp  = 20;
  localparam int preload_ops_lp = mem_bytes_lp / 8;
  localparam int random_ops_lp  = 600;
  localparam int max_ops_lp     = preload_ops_lp + 2 * random_ops_lp; // Writes get a readback.

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     v_i;
  dmem_pkg::dmem_opcode_e   opcode_i;
  logic [addr_width_lp-1:0] addr_i;
  logic [63:0]              data_i;
  logic [7:0]               mask_i;
  logic                     ready_o;
  logic                     v_o;
  logic [63:0]              data_o;

  integer     seed = 32'h9ded_cece;
  logic [7:0] model_mem [mem_bytes_lp];

  dmem_top #(.addr_width_p(addr_width_lp)) DUT (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .opcode_i (opcode_i),
    .addr_i   (addr_i),
    .data_i   (data_i),
    .mask_i   (mask_i),
    .ready_o  (ready_o),
    .v_o      (v_o),
    .data_o   (data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  initial begin
    #(max_ops_lp * 4 * clk_period_lp * 2);
    stop_on_failure("Timeout: the run took longer than its operations allow.");
  end

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping at the first failure.");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_on_failure($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic int op_bytes(input dmem_pkg::dmem_opcode_e op);
    if (op inside {dmem_pkg::LB, dmem_pkg::LBU, dmem_pkg::SB}) return 1;
    if (op inside {dmem_pkg::LH, dmem_pkg::LHU, dmem_pkg::SH}) return 2;
    if (op inside {dmem_pkg::LW, dmem_pkg::LWU, dmem_pkg::SW}) return 4;
    if (op >= dmem_pkg::AMOSWAP_W && op <= dmem_pkg::AMOMAXU_W) return 4;
    return 8; // D accesses, LM and SM cover the whole word.
  endfunction

  function automatic logic [63:0] model_read(input int base, input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = model_mem[base + i];
    end
    return v;
  endfunction

  function automatic void model_write(input int base, input int n, input logic [63:0] v);
    for (int i = 0; i < n; i++) begin
      model_mem[base + i] = v[8*i +: 8];
    end
  endfunction

  function automatic logic [63:0] extend(input logic [63:0] v, input int n, input logic sgn);
    case (n)
      1:       return {{56{sgn & v[7]}}, v[7:0]};
      2:       return {{48{sgn & v[15]}}, v[15:0]};
      4:       return {{32{sgn & v[31]}}, v[31:0]};
      default: return v;
    endcase
  endfunction

  // Kind follows the opcode order: swap, add, xor, and, or, min, max, minu, maxu.
  function automatic logic [63:0] amo_result(input int kind, input int n,
                                             input logic [63:0] a, input logic [63:0] b);
    logic lt_s;
    logic lt_u;
    if (n == 4) begin
      lt_s = $signed(a[31:0]) < $signed(b[31:0]);
      lt_u = a[31:0] < b[31:0];
    end else begin
      lt_s = $signed(a) < $signed(b);
      lt_u = a < b;
    end
    case (kind)
      0:       return b;
      1:       return a + b;
      2:       return a ^ b;
      3:       return a & b;
      4:       return a | b;
      5:       return lt_s ? a : b;
      6:       return lt_s ? b : a;
      7:       return lt_u ? a : b;
      default: return lt_u ? b : a;
    endcase
  endfunction

  // Returns the expected data_o and updates the model with the access.
  function automatic logic [63:0] apply_model(input dmem_pkg::dmem_opcode_e op,
                                              input logic [addr_width_lp-1:0] addr,
                                              input logic [63:0] data, input logic [7:0] mask);
    int          n;
    int          base;
    int          kind;
    logic [63:0] old;
    n    = op_bytes(op);
    base = int'(addr) / n * n; // Aligned down to the access size.
    old  = model_read(base, n);
    if (op == dmem_pkg::LM || op == dmem_pkg::SM) begin
      for (int i = 0; i < 8; i++) begin
        if (!mask[i]) begin
          old[8*i +: 8] = 8'h00;
        end else if (op == dmem_pkg::SM) begin
          model_mem[base + i] = data[8*i +: 8];
        end
      end
      return (op == dmem_pkg::LM) ? old : 64'd0;
    end
    if (op inside {dmem_pkg::SB, dmem_pkg::SH, dmem_pkg::SW, dmem_pkg::SD}) begin
      model_write(base, n, data);
      return 64'd0;
    end
    if (op < dmem_pkg::SB) begin
      return extend(old, n, op inside {dmem_pkg::LB, dmem_pkg::LH, dmem_pkg::LW, dmem_pkg::LD});
    end
    if (n == 4) begin
      kind = int'(op) - int'(dmem_pkg::AMOSWAP_W);
    end else begin
      kind = int'(op) - int'(dmem_pkg::AMOSWAP_D);
    end
    model_write(base, n, amo_result(kind, n, old, data));
    return extend(old, n, 1'b1);
  endfunction

  task automatic run_op(input dmem_pkg::dmem_opcode_e op, input logic [addr_width_lp-1:0] addr,
                        input logic [63:0] data, input logic [7:0] mask, input logic noise,
                        output logic [63:0] rsp);
    int          cycles;
    logic [31:0] rnd;
    cycles = 0;
    while (!ready_o && cycles < 8) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!ready_o) stop_on_failure("ready_o did not return high before a new request.");
    @(posedge clk_i);
    v_i      <= 1'b1;
    opcode_i <= op;
    addr_i   <= addr;
    data_i   <= data;
    mask_i   <= mask;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      rnd = $random(seed);
      v_i      <= noise; // A strobe while busy must be dropped.
      opcode_i <= dmem_pkg::dmem_opcode_e'(rnd[4:0]);
      addr_i   <= rnd[14:5];
      data_i   <= {rnd, ~rnd};
      mask_i   <= rnd[31:24];
      @(negedge clk_i);
      check_value("ready_o while busy", 64'd0, 64'(ready_o));
    end while (!v_o && cycles < 8);
    if (!v_o) stop_on_failure("v_o never rose after an accepted request.");
    check_value("v_o latency in edges", 64'd2, 64'(cycles));
    rsp = data_o;
    @(posedge clk_i);
    v_i <= 1'b0;
    @(negedge clk_i);
    check_value("v_o after result", 64'd0, 64'(v_o));
    check_value("ready_o after result", 64'd1, 64'(ready_o));
  endtask

  initial begin
    logic [63:0]              expected;
    logic [63:0]              actual;
    logic [63:0]              data;
    logic [31:0]              rnd;
    logic [addr_width_lp-1:0] addr;
    dmem_pkg::dmem_opcode_e   op;
    arst_n_i = 1'b0;
    v_i      = 1'b0;
    opcode_i = dmem_pkg::LB;
    addr_i   = '0;
    data_i   = '0;
    mask_i   = '0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("ready_o after reset", 64'd1, 64'(ready_o));
    check_value("v_o after reset", 64'd0, 64'(v_o));

    // The SRAM has no reset, so every word is written before it is read.
    for (int w = 0; w < preload_ops_lp; w++) begin
      data     = {$random(seed), $random(seed)};
      addr     = addr_width_lp'(w * 8);
      expected = apply_model(dmem_pkg::SD, addr, data, 8'h00);
      run_op(dmem_pkg::SD, addr, data, 8'h00, 1'b0, actual);
      check_value("preload SD", expected, actual);
    end

    for (int k = 0; k < random_ops_lp; k++) begin
      rnd      = $random(seed);
      op       = dmem_pkg::dmem_opcode_e'(rnd[4:0]);
      addr     = rnd[14:5];
      data     = {$random(seed), $random(seed)};
      expected = apply_model(op, addr, data, rnd[23:16]);
      run_op(op, addr, data, rnd[23:16], rnd[31:30] == 2'b11, actual);
      check_value($sformatf("%s at %h", op.name(), addr), expected, actual);
      if (op inside {dmem_pkg::SB, dmem_pkg::SH, dmem_pkg::SW, dmem_pkg::SD, dmem_pkg::SM}
          || op >= dmem_pkg::AMOSWAP_W) begin
        expected = apply_model(dmem_pkg::LDU, addr, 64'd0, 8'h00);
        run_op(dmem_pkg::LDU, addr, 64'd0, 8'h00, 1'b0, actual);
        check_value($sformatf("readback after %s at %h", op.name(), addr), expected, actual);
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* verilog/dmem_amo_alu.sv */
/* Atomic ALU.
   Combines the old memory value with the operand on a 32- or 64-bit lane. */

`timescale 1ns/1ns

module dmem_amo_alu (
  dmem_req_if.dp                             req,
  input  logic [dmem_pkg::data_width_lp-1:0] mem_data_i,
  output logic [dmem_pkg::data_width_lp-1:0] amo_data_o
);

  logic        is_double;
  logic [31:0] lane_w;
  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] result;

  assign is_double = (req.decode.data_size == dmem_pkg::e_size_double);
  assign lane_w    = req.byte_offset[2] ? mem_data_i[63:32] : mem_data_i[31:0];

  // Sign extension keeps both the signed and the unsigned order of word operands.
  assign op_a = is_double ? mem_data_i : {{32{lane_w[31]}}, lane_w};
  assign op_b = is_double ? req.store_data
                          : {{32{req.store_data[31]}}, req.store_data[31:0]};

  always_comb begin
    case (req.decode.amo_subop)
      dmem_pkg::e_amo_add:  result = op_a + op_b;
      dmem_pkg::e_amo_xor:  result = op_a ^ op_b;
      dmem_pkg::e_amo_and:  result = op_a & op_b;
      dmem_pkg::e_amo_or:   result = op_a | op_b;
      dmem_pkg::e_amo_min:  result = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
      dmem_pkg::e_amo_max:  result = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
      dmem_pkg::e_amo_minu: result = (op_a < op_b) ? op_a : op_b;
      dmem_pkg::e_amo_maxu: result = (op_a > op_b) ? op_a : op_b;
      default:              result = op_b; // Swap.
    endcase
  end

  // A word result sits in both lanes. The write enables pick the right one.
  assign amo_data_o = is_double ? result : {result[31:0], result[31:0]};

endmodule

/* verilog/dmem_ctrl.sv */
/* Request controller.
   Registers one request and steps it through SRAM read, result and write. */

`timescale 1ns/1ns

module dmem_ctrl #(
  parameter int addr_width_p = 10
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               v_i,
  input  dmem_pkg::dmem_decode_s             decode_i,
  input  logic [addr_width_p-1:0]            addr_i,
  input  logic [dmem_pkg::data_width_lp-1:0] data_i,
  input  logic [dmem_pkg::mask_width_lp-1:0] mask_i,
  output logic                               ready_o,
  output logic                               v_o,
  output logic [addr_width_p-4:0]            sram_addr_o,
  output logic                               sram_rd_en_o,
  output logic                               sram_wr_en_o,
  dmem_req_if.ctrl                           req
);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    READ = 2'd1,
    DONE = 2'd2
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   accept;

  assign accept = v_i && (state_r == IDLE);

  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE:    state_n = accept ? READ : IDLE;
      READ:    state_n = DONE; // Read data lands at the end of this cycle.
      DONE:    state_n = IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req.decode      <= decode_i;
      req.word_addr   <= addr_i[addr_width_p-1:3];
      req.byte_offset <= addr_i[2:0];
      req.store_data  <= data_i;
      req.store_mask  <= mask_i;
    end
  end

  assign ready_o      = (state_r == IDLE);
  assign v_o          = (state_r == DONE);
  assign sram_addr_o  = req.word_addr; // Same word for the read and the write-back.
  assign sram_rd_en_o = (state_r == READ);
  assign sram_wr_en_o = (state_r == DONE) && (req.decode.st_op || req.decode.atomic_op);

endmodule

/* verilog/dmem_decode.sv */
/* Opcode decoder.
   Maps a packet opcode to size, operation flags and atomic sub-opcode. */

`timescale 1ns/1ns

module dmem_decode (
  input  dmem_pkg::dmem_opcode_e opcode_i,
  output dmem_pkg::dmem_decode_s decode_o
);

  always_comb begin
    decode_o = '0;
    decode_o.amo_subop = dmem_pkg::e_amo_swap;

    case (opcode_i)
      dmem_pkg::LD, dmem_pkg::LDU, dmem_pkg::SD,
      dmem_pkg::AMOSWAP_D, dmem_pkg::AMOADD_D, dmem_pkg::AMOXOR_D,
      dmem_pkg::AMOAND_D, dmem_pkg::AMOOR_D, dmem_pkg::AMOMIN_D,
      dmem_pkg::AMOMAX_D, dmem_pkg::AMOMINU_D, dmem_pkg::AMOMAXU_D:
        decode_o.data_size = dmem_pkg::e_size_double;
      dmem_pkg::LW, dmem_pkg::LWU, dmem_pkg::SW,
      dmem_pkg::AMOSWAP_W, dmem_pkg::AMOADD_W, dmem_pkg::AMOXOR_W,
      dmem_pkg::AMOAND_W, dmem_pkg::AMOOR_W, dmem_pkg::AMOMIN_W,
      dmem_pkg::AMOMAX_W, dmem_pkg::AMOMINU_W, dmem_pkg::AMOMAXU_W:
        decode_o.data_size = dmem_pkg::e_size_word;
      dmem_pkg::LH, dmem_pkg::LHU, dmem_pkg::SH:
        decode_o.data_size = dmem_pkg::e_size_half;
      default:
        decode_o.data_size = dmem_pkg::e_size_byte; // LM and SM ignore the size.
    endcase

    decode_o.mask_op = (opcode_i == dmem_pkg::LM) || (opcode_i == dmem_pkg::SM);

    decode_o.ld_op = (opcode_i inside {dmem_pkg::LB, dmem_pkg::LH, dmem_pkg::LW,
                                       dmem_pkg::LD, dmem_pkg::LBU, dmem_pkg::LHU,
                                       dmem_pkg::LWU, dmem_pkg::LDU, dmem_pkg::LM});

    decode_o.st_op = (opcode_i inside {dmem_pkg::SB, dmem_pkg::SH, dmem_pkg::SW,
                                       dmem_pkg::SD, dmem_pkg::SM});

    decode_o.atomic_op = 1'b1;
    case (opcode_i)
      dmem_pkg::AMOSWAP_W, dmem_pkg::AMOSWAP_D: decode_o.amo_subop = dmem_pkg::e_amo_swap;
      dmem_pkg::AMOADD_W, dmem_pkg::AMOADD_D:   decode_o.amo_subop = dmem_pkg::e_amo_add;
      dmem_pkg::AMOXOR_W, dmem_pkg::AMOXOR_D:   decode_o.amo_subop = dmem_pkg::e_amo_xor;
      dmem_pkg::AMOAND_W, dmem_pkg::AMOAND_D:   decode_o.amo_subop = dmem_pkg::e_amo_and;
      dmem_pkg::AMOOR_W, dmem_pkg::AMOOR_D:     decode_o.amo_subop = dmem_pkg::e_amo_or;
      dmem_pkg::AMOMIN_W, dmem_pkg::AMOMIN_D:   decode_o.amo_subop = dmem_pkg::e_amo_min;
      dmem_pkg::AMOMAX_W, dmem_pkg::AMOMAX_D:   decode_o.amo_subop = dmem_pkg::e_amo_max;
      dmem_pkg::AMOMINU_W, dmem_pkg::AMOMINU_D: decode_o.amo_subop = dmem_pkg::e_amo_minu;
      dmem_pkg::AMOMAXU_W, dmem_pkg::AMOMAXU_D: decode_o.amo_subop = dmem_pkg::e_amo_maxu;
      default: begin
        decode_o.atomic_op = 1'b0;
        decode_o.amo_subop = dmem_pkg::e_amo_swap;
      end
    endcase

    // Atomics hand back the old value sign-extended, like the signed loads.
    decode_o.sigext_op = decode_o.atomic_op
                         || (opcode_i inside {dmem_pkg::LB, dmem_pkg::LH,
                                              dmem_pkg::LW, dmem_pkg::LD});
  end

endmodule

/* verilog/dmem_load_align.sv */
/* Load aligner.
   Picks the addressed lane from the read word and extends it to 64 bits. */

`timescale 1ns/1ns

module dmem_load_align (
  dmem_req_if.dp                             req,
  input  logic [dmem_pkg::data_width_lp-1:0] mem_data_i,
  output logic [dmem_pkg::data_width_lp-1:0] data_o
);

  logic [2:0]  lane_off;
  logic [63:0] shifted;
  logic [63:0] byte_keep;

  always_comb begin
    case (req.decode.data_size)
      dmem_pkg::e_size_byte: lane_off = req.byte_offset;
      dmem_pkg::e_size_half: lane_off = {req.byte_offset[2:1], 1'b0};
      dmem_pkg::e_size_word: lane_off = {req.byte_offset[2], 2'b00};
      default:               lane_off = 3'b000;
    endcase
  end

  assign shifted = mem_data_i >> {lane_off, 3'b000};

  always_comb begin
    for (int i = 0; i < dmem_pkg::mask_width_lp; i++) begin
      byte_keep[8*i +: 8] = {8{req.store_mask[i]}};
    end
  end

  always_comb begin
    if (!req.decode.ld_op && !req.decode.atomic_op) begin
      data_o = '0; // Stores, including SM, answer with zero.
    end else if (req.decode.mask_op) begin
      data_o = mem_data_i & byte_keep;
    end else begin
      case (req.decode.data_size)
        dmem_pkg::e_size_byte:
          data_o = {{56{req.decode.sigext_op & shifted[7]}}, shifted[7:0]};
        dmem_pkg::e_size_half:
          data_o = {{48{req.decode.sigext_op & shifted[15]}}, shifted[15:0]};
        dmem_pkg::e_size_word:
          data_o = {{32{req.decode.sigext_op & shifted[31]}}, shifted[31:0]};
        default:
          data_o = shifted;
      endcase
    end
  end

endmodule

/* verilog/dmem_pkg.sv */
/* Data-memory unit package.
   Opcodes, atomic sub-opcodes, access sizes and the decode bundle. */

package dmem_pkg;

  localparam int data_width_lp = 64; // Width of one SRAM word.
  localparam int mask_width_lp = data_width_lp / 8; // One enable per byte.

  typedef enum logic [4:0] {
    LB        = 5'd0,
    LH        = 5'd1,
    LW        = 5'd2,
    LD        = 5'd3,
    LBU       = 5'd4,
    LHU       = 5'd5,
    LWU       = 5'd6,
    LDU       = 5'd7,
    SB        = 5'd8,
    SH        = 5'd9,
    SW        = 5'd10,
    SD        = 5'd11,
    LM        = 5'd12,
    SM        = 5'd13,
    AMOSWAP_W = 5'd14,
    AMOADD_W  = 5'd15,
    AMOXOR_W  = 5'd16,
    AMOAND_W  = 5'd17,
    AMOOR_W   = 5'd18,
    AMOMIN_W  = 5'd19,
    AMOMAX_W  = 5'd20,
    AMOMINU_W = 5'd21,
    AMOMAXU_W = 5'd22,
    AMOSWAP_D = 5'd23,
    AMOADD_D  = 5'd24,
    AMOXOR_D  = 5'd25,
    AMOAND_D  = 5'd26,
    AMOOR_D   = 5'd27,
    AMOMIN_D  = 5'd28,
    AMOMAX_D  = 5'd29,
    AMOMINU_D = 5'd30,
    AMOMAXU_D = 5'd31
  } dmem_opcode_e;

  typedef enum logic [3:0] {
    e_amo_swap = 4'd0,
    e_amo_add  = 4'd1,
    e_amo_xor  = 4'd2,
    e_amo_and  = 4'd3,
    e_amo_or   = 4'd4,
    e_amo_min  = 4'd5,
    e_amo_max  = 4'd6,
    e_amo_minu = 4'd7,
    e_amo_maxu = 4'd8
  } dmem_amo_subop_e;

  typedef enum logic [1:0] {
    e_size_byte   = 2'b00,
    e_size_half   = 2'b01,
    e_size_word   = 2'b10,
    e_size_double = 2'b11
  } dmem_size_e;

  typedef struct packed {
    dmem_size_e      data_size;
    logic            mask_op;
    logic            sigext_op;
    logic            ld_op;
    logic            st_op;
    logic            atomic_op;
    dmem_amo_subop_e amo_subop;
  } dmem_decode_s;

endpackage

/* verilog/dmem_req_if.sv */
/* Registered request bundle.
   Driven by the controller and read by the datapath blocks. */

`timescale 1ns/1ns

interface dmem_req_if #(
  parameter int addr_width_p = 10
);

  dmem_pkg::dmem_decode_s                   decode;
  logic [addr_width_p-4:0]                  word_addr;
  logic [2:0]                               byte_offset;
  logic [dmem_pkg::data_width_lp-1:0]       store_data;
  logic [dmem_pkg::mask_width_lp-1:0]       store_mask;

  modport ctrl (
    output decode, word_addr, byte_offset, store_data, store_mask
  );

  modport dp (
    input decode, word_addr, byte_offset, store_data, store_mask
  );

endinterface

/* verilog/dmem_sram.sv */
/* Local data SRAM.
   64-bit words, registered read port and byte-enabled write. */

`timescale 1ns/1ns

module dmem_sram #(
  parameter int addr_width_p = 10
) (
  input  logic                               clk_i,
  input  logic [addr_width_p-4:0]            addr_i,
  input  logic                               rd_en_i,
  input  logic                               wr_en_i,
  input  logic [dmem_pkg::data_width_lp-1:0] wr_data_i,
  input  logic [dmem_pkg::mask_width_lp-1:0] wr_mask_i,
  output logic [dmem_pkg::data_width_lp-1:0] rd_data_o
);

  localparam int depth_lp = 2 ** (addr_width_p - 3);

  logic [dmem_pkg::data_width_lp-1:0] mem [depth_lp];

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem[addr_i]; // Holds its value until the next read.
    end
    if (wr_en_i) begin
      for (int i = 0; i < dmem_pkg::mask_width_lp; i++) begin
        if (wr_mask_i[i]) begin
          mem[addr_i][8*i +: 8] <= wr_data_i[8*i +: 8];
        end
      end
    end
  end

endmodule

/* verilog/dmem_top.sv */
/* Data-memory unit top level.
   Connects decoder, controller, SRAM and the load/store datapath. */

`timescale 1ns/1ns

module dmem_top #(
  parameter int addr_width_p = 10
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               v_i,
  input  dmem_pkg::dmem_opcode_e             opcode_i,
  input  logic [addr_width_p-1:0]            addr_i,
  input  logic [dmem_pkg::data_width_lp-1:0] data_i,
  input  logic [dmem_pkg::mask_width_lp-1:0] mask_i,
  output logic                               ready_o,
  output logic                               v_o,
  output logic [dmem_pkg::data_width_lp-1:0] data_o
);

  dmem_pkg::dmem_decode_s             decode;
  logic [addr_width_p-4:0]            sram_addr;
  logic                               sram_rd_en;
  logic                               sram_wr_en;
  logic [dmem_pkg::data_width_lp-1:0] sram_rd_data;
  logic [dmem_pkg::data_width_lp-1:0] sram_wr_data;
  logic [dmem_pkg::mask_width_lp-1:0] sram_wr_mask;
  logic [dmem_pkg::data_width_lp-1:0] amo_data;

  dmem_req_if #(.addr_width_p(addr_width_p)) req_if ();

  dmem_decode u_decode (
    .opcode_i (opcode_i),
    .decode_o (decode)
  );

  dmem_ctrl #(.addr_width_p(addr_width_p)) u_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .v_i          (v_i),
    .decode_i     (decode),
    .addr_i       (addr_i),
    .data_i       (data_i),
    .mask_i       (mask_i),
    .ready_o      (ready_o),
    .v_o          (v_o),
    .sram_addr_o  (sram_addr),
    .sram_rd_en_o (sram_rd_en),
    .sram_wr_en_o (sram_wr_en),
    .req          (req_if.ctrl)
  );

  dmem_sram #(.addr_width_p(addr_width_p)) u_sram (
    .clk_i     (clk_i),
    .addr_i    (sram_addr),
    .rd_en_i   (sram_rd_en),
    .wr_en_i   (sram_wr_en),
    .wr_data_i (sram_wr_data),
    .wr_mask_i (sram_wr_mask),
    .rd_data_o (sram_rd_data)
  );

  dmem_amo_alu u_amo_alu (
    .req        (req_if.dp),
    .mem_data_i (sram_rd_data),
    .amo_data_o (amo_data)
  );

  dmem_write_merge u_write_merge (
    .req        (req_if.dp),
    .amo_data_i (amo_data),
    .wr_data_o  (sram_wr_data),
    .wr_mask_o  (sram_wr_mask)
  );

  dmem_load_align u_load_align (
    .req        (req_if.dp),
    .mem_data_i (sram_rd_data),
    .data_o     (data_o)
  );

endmodule

/* verilog/dmem_write_merge.sv */
/* Write merge.
   Builds the SRAM write word and byte enables for stores and atomics. */

`timescale 1ns/1ns

module dmem_write_merge (
  dmem_req_if.dp                             req,
  input  logic [dmem_pkg::data_width_lp-1:0] amo_data_i,
  output logic [dmem_pkg::data_width_lp-1:0] wr_data_o,
  output logic [dmem_pkg::mask_width_lp-1:0] wr_mask_o
);

  logic [2:0] off;

  assign off = req.byte_offset;

  always_comb begin
    if (req.decode.atomic_op) begin
      wr_data_o = amo_data_i;
      if (req.decode.data_size == dmem_pkg::e_size_double) begin
        wr_mask_o = 8'hff;
      end else begin
        wr_mask_o = off[2] ? 8'hf0 : 8'h0f;
      end
    end else if (req.decode.mask_op) begin
      wr_data_o = req.store_data; // SM writes the word as given.
      wr_mask_o = req.store_mask;
    end else begin
      case (req.decode.data_size)
        dmem_pkg::e_size_byte: begin
          wr_data_o = {8{req.store_data[7:0]}};
          wr_mask_o = 8'h01 << off;
        end
        dmem_pkg::e_size_half: begin
          wr_data_o = {4{req.store_data[15:0]}};
          wr_mask_o = 8'h03 << {off[2:1], 1'b0};
        end
        dmem_pkg::e_size_word: begin
          wr_data_o = {2{req.store_data[31:0]}};
          wr_mask_o = 8'h0f << {off[2], 2'b00};
        end
        default: begin
          wr_data_o = req.store_data;
          wr_mask_o = 8'hff;
        end
      endcase
    end
  end

endmodule
